// ==== Bender.yml ====
package:
  name: audio_engine

sources:
  - logic/audio_pkg.sv
  - logic/dpram.sv
  - logic/bus_regs.sv
  - logic/i2s_clock.sv
  - logic/i2s_serdes.sv
  - logic/sequencer.sv
  - logic/mac_unit.sv
  - logic/audio_engine.sv
  - target: test
    files:
      - testbench/audio_engine_chk.sv
      - testbench/audio_engine_tb.sv

// ==== build.f ====
logic/audio_pkg.sv
logic/dpram.sv
logic/bus_regs.sv
logic/i2s_clock.sv
logic/i2s_serdes.sv
logic/sequencer.sv
logic/mac_unit.sv
logic/audio_engine.sv
testbench/audio_engine_chk.sv
testbench/audio_engine_tb.sv

// ==== logic/audio_engine.sv ====
/*
 * Audio DSP peripheral top. Bus slave, program and audio RAMs,
 * sequencer, MAC and I2S, plus the audio RAM write-port mux.
 */
`timescale 1ns/1ps
`default_nettype none

module audio_engine (
    input  wire         ck,
    input  wire         rst_n,
    input  wire         iomem_valid,
    input  wire [3:0]   iomem_wstrb,
    input  wire [31:0]  iomem_addr,
    input  wire [31:0]  iomem_wdata,
    input  wire         sd_in,
    output logic        iomem_ready,
    output logic [31:0] iomem_rdata,
    output logic        sck,
    output logic        ws,
    output logic        sd
);
    import audio_pkg::*;

    logic core_rst_n;
    logic soft_rst;
    logic host_audio;
    logic coef_we;
    logic host_audio_we;
    instr_t coef_rdata;
    code_addr_t coef_raddr;
    logic audio_we;
    chan_t audio_waddr;
    chan_t audio_raddr;
    sample_t audio_wdata;
    sample_t audio_rdata;
    sample_t coef;
    sample_t left;
    sample_t right;
    sample_t mic_0;
    sample_t mic_1;
    logic mac_en;
    logic out_en;
    logic out_side;
    logic done;
    logic error;
    logic sck_fall;
    logic sck_rise;
    posn_t posn;
    logic frame_start;
    logic wr_ch1;

    // Soft reset clears the engine, I2S timing keeps running
    assign core_rst_n = rst_n && !soft_rst;

    bus_regs bus_regs_i (
        .ck(ck), .rst_n(rst_n), .iomem_valid(iomem_valid), .iomem_wstrb(iomem_wstrb),
        .iomem_addr(iomem_addr), .iomem_wdata(iomem_wdata), .left(left), .right(right),
        .done(done), .error(error), .iomem_ready(iomem_ready), .iomem_rdata(iomem_rdata),
        .coef_we(coef_we), .audio_we(host_audio_we), .soft_rst(soft_rst),
        .host_audio(host_audio)
    );

    dpram #(.WIDTH(32), .DEPTH(CODE_WORDS)) coef_ram_i (
        .ck(ck), .we(coef_we), .waddr(iomem_addr[7:2]), .wdata(iomem_wdata),
        .raddr(coef_raddr), .rdata(coef_rdata)
    );

    // Second cycle of the I2S input write goes to channel 1
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            wr_ch1 <= 1'b0;
        end else begin
            wr_ch1 <= frame_start && !host_audio;
        end
    end

    // Audio write port owned by host or by I2S input
    always_comb begin
        if (host_audio) begin
            audio_we = host_audio_we;
            audio_waddr = iomem_addr[5:2];
            audio_wdata = iomem_wdata[15:0];
        end else begin
            audio_we = frame_start || wr_ch1;
            audio_waddr = wr_ch1 ? chan_t'(1) : chan_t'(0);
            audio_wdata = wr_ch1 ? mic_1 : mic_0;
        end
    end

    dpram #(.WIDTH(16), .DEPTH(CHANNELS)) audio_ram_i (
        .ck(ck), .we(audio_we), .waddr(audio_waddr), .wdata(audio_wdata),
        .raddr(audio_raddr), .rdata(audio_rdata)
    );

    sequencer sequencer_i (
        .ck(ck), .rst_n(core_rst_n), .frame_start(frame_start), .coef_rdata(coef_rdata),
        .coef_raddr(coef_raddr), .audio_raddr(audio_raddr), .coef(coef), .mac_en(mac_en),
        .out_en(out_en), .out_side(out_side), .done(done), .error(error)
    );

    mac_unit mac_unit_i (
        .ck(ck), .rst_n(core_rst_n), .clear(frame_start), .sample(audio_rdata),
        .coef(coef), .mac_en(mac_en), .out_en(out_en), .out_side(out_side),
        .left(left), .right(right)
    );

    i2s_clock i2s_clock_i (
        .ck(ck), .rst_n(rst_n), .sck(sck), .ws(ws), .sck_fall(sck_fall),
        .sck_rise(sck_rise), .posn(posn), .frame_start(frame_start)
    );

    i2s_serdes i2s_serdes_i (
        .ck(ck), .rst_n(rst_n), .sck_fall(sck_fall), .sck_rise(sck_rise), .posn(posn),
        .frame_start(frame_start), .left(left), .right(right), .sd_in(sd_in),
        .sd(sd), .mic_0(mic_0), .mic_1(mic_1)
    );

endmodule

`default_nettype wire

// ==== logic/audio_pkg.sv ====
/*
 * Shared types, address map, instruction fields and opcodes for the
 * audio MAC peripheral. Imported by every RTL block that needs them.
 */
`default_nettype none

package audio_pkg;

    // Data widths with a meaning
    typedef logic signed [15:0] sample_t;
    typedef logic signed [39:0] acc_t;
    typedef logic [31:0] instr_t;
    typedef logic [5:0] code_addr_t;
    typedef logic [3:0] chan_t;
    typedef logic [5:0] posn_t;

    localparam int CODE_WORDS = 64;
    localparam int CHANNELS = 16;

    // Saturation limits for Q1.15 results
    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

    // Instruction word layout
    localparam int OP_HI = 31;
    localparam int OP_LO = 28;
    localparam int CHAN_HI = 27;
    localparam int CHAN_LO = 24;
    localparam int SIDE_BIT = 16;
    localparam int COEF_HI = 15;
    localparam int COEF_LO = 0;

    // Opcodes, anything else runs as a NOP
    localparam logic [3:0] OP_NOP = 4'h0;
    localparam logic [3:0] OP_MAC = 4'h1;
    localparam logic [3:0] OP_OUT = 4'h2;
    localparam logic [3:0] OP_HALT = 4'hf;

    // Bus regions, matched on address bits 15:8
    localparam logic [15:0] BASE_ADDR = 16'h6000;
    localparam logic [15:0] ADDR_COEF = BASE_ADDR + 16'h0000;
    localparam logic [15:0] ADDR_RESULT = BASE_ADDR + 16'h0100;
    localparam logic [15:0] ADDR_STATUS = BASE_ADDR + 16'h0200;
    localparam logic [15:0] ADDR_RESET = BASE_ADDR + 16'h0300;
    localparam logic [15:0] ADDR_INPUT = BASE_ADDR + 16'h0400;

    // sck half period in ck cycles
    localparam int SCK_HALF = 1;
    localparam int DIV_W = $clog2(SCK_HALF + 1);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DECODE,
        EXEC
    } seq_state_t;

endpackage

`default_nettype wire

// ==== logic/bus_regs.sv ====
/*
 * Memory-mapped bus slave: region decode, one-cycle ready, control bit,
 * soft reset strobe and read data for results and status.
 */
`timescale 1ns/1ps
`default_nettype none

module bus_regs (
    input  wire                    ck,
    input  wire                    rst_n,
    input  wire                    iomem_valid,
    input  wire [3:0]              iomem_wstrb,
    input  wire [31:0]             iomem_addr,
    input  wire [31:0]             iomem_wdata,
    input  wire audio_pkg::sample_t left,
    input  wire audio_pkg::sample_t right,
    input  wire                    done,
    input  wire                    error,
    output logic                   iomem_ready,
    output logic [31:0]            iomem_rdata,
    output logic                   coef_we,
    output logic                   audio_we,
    output logic                   soft_rst,
    output logic                   host_audio
);
    import audio_pkg::*;

    logic sel_coef;
    logic sel_result;
    logic sel_status;
    logic sel_reset;
    logic sel_input;
    logic mapped;
    logic is_write;
    logic wr_cycle;
    logic [31:0] rd_mux;

    // Region select on address bits 15:8
    assign sel_coef = iomem_addr[15:8] == ADDR_COEF[15:8];
    assign sel_result = iomem_addr[15:8] == ADDR_RESULT[15:8];
    assign sel_status = iomem_addr[15:8] == ADDR_STATUS[15:8];
    assign sel_reset = iomem_addr[15:8] == ADDR_RESET[15:8];
    assign sel_input = iomem_addr[15:8] == ADDR_INPUT[15:8];
    assign mapped = sel_coef | sel_result | sel_status | sel_reset | sel_input;
    assign is_write = |iomem_wstrb;

    // Ready one cycle after valid, never twice in a row
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            iomem_ready <= 1'b0;
        end else begin
            iomem_ready <= iomem_valid && mapped && !iomem_ready;
        end
    end

    // Writes land in the ready cycle, address still held by host
    assign wr_cycle = iomem_ready && is_write;
    assign coef_we = wr_cycle && sel_coef;
    assign audio_we = wr_cycle && sel_input;
    assign soft_rst = wr_cycle && sel_reset;

    // Control bit 0 hands the audio RAM write port to the host
    always_ff @(posedge ck) begin
        if (!rst_n || soft_rst) begin
            host_audio <= 1'b0;
        end else if (wr_cycle && sel_status) begin
            host_audio <= iomem_wdata[0];
        end
    end

    always_comb begin
        rd_mux = '0;
        if (sel_result) begin
            // Offset 4 selects right
            rd_mux = {16'h0, iomem_addr[2] ? right : left};
        end else if (sel_status) begin
            rd_mux = {30'h0, error, done};
        end
    end

    // Read data only in the ready cycle
    assign iomem_rdata = (iomem_ready && !is_write) ? rd_mux : 32'h0;

endmodule

`default_nettype wire

// ==== logic/dpram.sv ====
/*
 * Dual-port RAM, one write port and one registered read port.
 * Holds the program words and the audio channels.
 */
`timescale 1ns/1ps
`default_nettype none

module dpram #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 16
) (
    input  wire                       ck,
    input  wire                       we,
    input  wire [$clog2(DEPTH)-1:0]   waddr,
    input  wire [WIDTH-1:0]           wdata,
    input  wire [$clog2(DEPTH)-1:0]   raddr,
    output logic [WIDTH-1:0]          rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Read sees a write made on an earlier edge
    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== logic/i2s_clock.sv ====
/*
 * I2S bit clock and word select from ck. Gives sck edge strobes,
 * the bit position within a 64-slot frame and a frame-start pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module i2s_clock (
    input  wire                 ck,
    input  wire                 rst_n,
    output logic                sck,
    output logic                ws,
    output logic                sck_fall,
    output logic                sck_rise,
    output audio_pkg::posn_t    posn,
    output logic                frame_start
);
    import audio_pkg::*;

    logic [DIV_W-1:0] div;
    logic tick;

    // sck toggles when the divider wraps
    assign tick = div == DIV_W'(SCK_HALF - 1);
    assign sck_rise = tick && !sck;
    assign sck_fall = tick && sck;

    // Left half of the frame with ws low
    assign ws = posn[5];

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            div <= '0;
            sck <= 1'b0;
            posn <= '0;
            frame_start <= 1'b0;
        end else begin
            if (tick) begin
                div <= '0;
                sck <= !sck;
            end else begin
                div <= div + 1'b1;
            end
            // Position moves on the falling sck edge
            if (sck_fall) begin
                posn <= posn + 1'b1;
            end
            // High in the first cycle of position 0
            frame_start <= sck_fall && posn == '1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/i2s_serdes.sv ====
/*
 * I2S data path. Sends the left and right words latched at frame start
 * on sd and collects two 16-bit words from sd_in for the next frame.
 */
`timescale 1ns/1ps
`default_nettype none

module i2s_serdes (
    input  wire                     ck,
    input  wire                     rst_n,
    input  wire                     sck_fall,
    input  wire                     sck_rise,
    input  wire audio_pkg::posn_t   posn,
    input  wire                     frame_start,
    input  wire audio_pkg::sample_t left,
    input  wire audio_pkg::sample_t right,
    input  wire                     sd_in,
    output logic                    sd,
    output audio_pkg::sample_t      mic_0,
    output audio_pkg::sample_t      mic_1
);
    import audio_pkg::*;

    logic [31:0] tx_shift;
    logic [31:0] rx_shift;
    posn_t nxt;
    logic tx_slot;
    logic rx_slot;

    // Data slots are positions 1..16 of each half
    assign nxt = posn + 1'b1;
    assign tx_slot = nxt[4:0] >= 5'd1 && nxt[4:0] <= 5'd16;
    assign rx_slot = posn[4:0] >= 5'd1 && posn[4:0] <= 5'd16;

    // Transmit, MSB first, updated as sck falls
    always_ff @(posedge ck) begin
        if (frame_start) begin
            tx_shift <= {left, right};
        end else if (sck_fall && tx_slot) begin
            tx_shift <= {tx_shift[30:0], 1'b0};
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            sd <= 1'b0;
        end else if (sck_fall) begin
            sd <= tx_slot ? tx_shift[31] : 1'b0;
        end
    end

    // Receive on rising sck at the same slots
    always_ff @(posedge ck) begin
        if (sck_rise && rx_slot) begin
            rx_shift <= {rx_shift[30:0], sd_in};
        end
    end

    // Words handed over as the frame wraps, stable through frame start
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            mic_0 <= '0;
            mic_1 <= '0;
        end else if (sck_fall && nxt == '0) begin
            mic_0 <= rx_shift[31:16];
            mic_1 <= rx_shift[15:0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/mac_unit.sv ====
/*
 * Signed multiply-accumulate with a 40-bit accumulator. OUT stores the
 * Q1.15 saturated result into the left or right register.
 */
`timescale 1ns/1ps
`default_nettype none

module mac_unit (
    input  wire                     ck,
    input  wire                     rst_n,
    input  wire                     clear,
    input  wire audio_pkg::sample_t sample,
    input  wire audio_pkg::sample_t coef,
    input  wire                     mac_en,
    input  wire                     out_en,
    input  wire                     out_side,
    output audio_pkg::sample_t      left,
    output audio_pkg::sample_t      right
);
    import audio_pkg::*;

    acc_t acc;
    acc_t shifted;
    sample_t sat;
    logic signed [31:0] product;

    assign product = sample * coef;

    // Back to Q1.15 scale
    assign shifted = acc >>> 15;

    always_comb begin
        if (shifted > acc_t'(SAMPLE_MAX)) begin
            sat = SAMPLE_MAX;
        end else if (shifted < acc_t'(SAMPLE_MIN)) begin
            sat = SAMPLE_MIN;
        end else begin
            sat = shifted[15:0];
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            acc <= '0;
            left <= '0;
            right <= '0;
        end else begin
            if (out_en) begin
                if (out_side) begin
                    right <= sat;
                end else begin
                    left <= sat;
                end
            end
            // Frame start and OUT both empty the accumulator
            if (clear || out_en) begin
                acc <= '0;
            end else if (mac_en) begin
                acc <= acc + acc_t'(product);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/sequencer.sv ====
/*
 * Program sequencer. Runs the coefficient RAM program once per frame,
 * three cycles per instruction, and strobes the MAC and output writes.
 */
`timescale 1ns/1ps
`default_nettype none

module sequencer (
    input  wire                         ck,
    input  wire                         rst_n,
    input  wire                         frame_start,
    input  wire audio_pkg::instr_t      coef_rdata,
    output audio_pkg::code_addr_t       coef_raddr,
    output audio_pkg::chan_t            audio_raddr,
    output audio_pkg::sample_t          coef,
    output logic                        mac_en,
    output logic                        out_en,
    output logic                        out_side,
    output logic                        done,
    output logic                        error
);
    import audio_pkg::*;

    seq_state_t state;
    code_addr_t pc;
    logic [3:0] opcode;
    logic in_exec;
    logic halt;
    logic last;

    // Program word stays on the read port until pc moves
    assign coef_raddr = pc;
    assign opcode = coef_rdata[OP_HI:OP_LO];
    assign audio_raddr = coef_rdata[CHAN_HI:CHAN_LO];
    assign coef = coef_rdata[COEF_HI:COEF_LO];
    assign out_side = coef_rdata[SIDE_BIT];

    // Strobes only in EXEC, when the audio sample is on the read port
    assign in_exec = state == EXEC;
    assign mac_en = in_exec && opcode == OP_MAC;
    assign out_en = in_exec && opcode == OP_OUT;
    assign halt = in_exec && opcode == OP_HALT;
    assign last = pc == code_addr_t'(CODE_WORDS - 1);

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            state <= IDLE;
            pc <= '0;
            done <= 1'b0;
            error <= 1'b0;
        end else begin
            if (frame_start) begin
                done <= 1'b0;
                // Overrun, the current run carries on
                if (state != IDLE) begin
                    error <= 1'b1;
                end
            end
            case (state)
                IDLE: begin
                    if (frame_start) begin
                        pc <= '0;
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    state <= DECODE;
                end
                DECODE: begin
                    state <= EXEC;
                end
                EXEC: begin
                    // Halt or end of program space finishes the run
                    if (halt || last) begin
                        done <= 1'b1;
                        state <= IDLE;
                    end else begin
                        pc <= pc + 1'b1;
                        state <= FETCH;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== testbench/audio_engine_chk.sv ====
/*
 * Protocol assertions bound into the audio engine top: bus ready,
 * MAC strobes and the flags right after a reset.
 */
`timescale 1ns/1ps
`default_nettype none

module audio_engine_chk (
    input wire ck,
    input wire rst_n,
    input wire soft_rst,
    input wire iomem_ready,
    input wire mac_en,
    input wire out_en,
    input wire done,
    input wire error
);

    // Number of assertion failures so far
    int fail_count = 0;

    // Single-cycle ready
    ready_single: assert property (@(posedge ck) disable iff (!rst_n)
        iomem_ready |=> !iomem_ready)
        else begin
            $error("iomem_ready high two cycles in a row");
            fail_count++;
        end

    // MAC and OUT are separate opcodes
    strobe_excl: assert property (@(posedge ck) disable iff (!rst_n)
        !(mac_en && out_en))
        else begin
            $error("mac_en and out_en high together");
            fail_count++;
        end

    // Either reset clears the flags
    flags_reset: assert property (@(posedge ck)
        (!rst_n || soft_rst) |=> (!done && !error))
        else begin
            $error("done or error set after reset");
            fail_count++;
        end

endmodule

bind audio_engine audio_engine_chk audio_engine_chk_i (
    .ck(ck), .rst_n(rst_n), .soft_rst(soft_rst), .iomem_ready(iomem_ready),
    .mac_en(mac_en), .out_en(out_en), .done(done), .error(error)
);

`default_nettype wire

// ==== testbench/audio_engine_tb.sv ====
/*
 * Testbench for the audio MAC peripheral. Drives the bus with random
 * programs and samples, follows the I2S frame on sd and sd_in, and
 * compares results with an arithmetic model kept here.
 */
`timescale 1ns/1ps
`default_nettype none

module audio_engine_tb;
    import audio_pkg::*;

    localparam int LIMIT = 20000;
    localparam int TRIALS = 8;

    logic ck;
    logic rst_n;
    logic iomem_valid;
    logic [3:0] iomem_wstrb;
    logic [31:0] iomem_addr;
    logic [31:0] iomem_wdata;
    logic sd_in;
    wire iomem_ready;
    wire [31:0] iomem_rdata;
    wire sck;
    wire ws;
    wire sd;

    integer seed = 32'h947c2437;
    int cycles = 0;
    // Frame follower state
    int pos = 0;
    int frame_cnt = 0;
    int words_frame = -1;
    logic prev_ws = 1'b0;
    logic prev_sck = 1'b0;
    logic synced = 1'b0;
    logic [15:0] rx_l;
    logic [15:0] rx_r;
    logic [15:0] word_l;
    logic [15:0] word_r;
    logic [15:0] in_l = '0;
    logic [15:0] in_r = '0;
    // Program and sample images for the model
    logic [31:0] prog [32];
    logic signed [15:0] samp [16];

    audio_engine audio_engine_i (
        .ck(ck), .rst_n(rst_n), .iomem_valid(iomem_valid), .iomem_wstrb(iomem_wstrb),
        .iomem_addr(iomem_addr), .iomem_wdata(iomem_wdata), .sd_in(sd_in),
        .iomem_ready(iomem_ready), .iomem_rdata(iomem_rdata), .sck(sck), .ws(ws), .sd(sd)
    );

    initial ck = 1'b0;
    always #4 ck = !ck;

    always @(posedge ck) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    // Bound protocol assertions count their failures
    always @(negedge ck) begin
        if (audio_engine_i.audio_engine_chk_i.fail_count != 0) begin
            $display("A bound protocol assertion failed");
            $display("ERRORS FOUND");
            $fatal(1, "assertion");
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch");
        end
    endtask

    // One sample per sck period, in the half where sck is high
    always @(negedge ck) begin
        // sck flips on every ck cycle
        if (synced) begin
            check_eq("sck", sck, !prev_sck);
        end
        prev_sck = sck;
        if (sck) begin
            if (prev_ws && !ws) begin
                pos = 0;
                synced = 1'b1;
                frame_cnt++;
            end else begin
                pos = (pos + 1) % 64;
            end
            prev_ws = ws;
            if (synced) begin
                // ws low for the left half of the frame
                check_eq("ws", ws, pos >= 32);
                if (pos >= 1 && pos <= 16) begin
                    rx_l = {rx_l[14:0], sd};
                end else if (pos >= 33 && pos <= 48) begin
                    rx_r = {rx_r[14:0], sd};
                end else begin
                    check_eq("sd idle slot", sd, 0);
                end
                if (pos == 48) begin
                    word_l = rx_l;
                    word_r = rx_r;
                    words_frame = frame_cnt;
                end
                // Data for the next position, MSB first
                if (pos + 1 >= 1 && pos + 1 <= 16) begin
                    sd_in = in_l[15 - pos];
                end else if (pos + 1 >= 33 && pos + 1 <= 48) begin
                    sd_in = in_r[47 - pos];
                end else begin
                    sd_in = 1'b0;
                end
            end
        end
    end

    task automatic bus_access(input logic [15:0] addr, input logic [31:0] data,
                              input logic write, output logic [31:0] rdata);
        iomem_valid = 1'b1;
        iomem_addr = {16'h0, addr};
        iomem_wdata = data;
        iomem_wstrb = write ? 4'hf : 4'h0;
        @(negedge ck);
        while (!iomem_ready) begin
            @(negedge ck);
        end
        rdata = iomem_rdata;
        // Request stays up through the ready cycle, where writes land
        @(negedge ck);
        iomem_valid = 1'b0;
        iomem_wstrb = 4'h0;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(addr, data, 1'b1, unused);
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        bus_access(addr, 32'h0, 1'b0, data);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_cnt + n;
        while (frame_cnt < target) begin
            @(negedge ck);
        end
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[0]) begin
            bus_read(ADDR_STATUS, st);
        end
    endtask

    function automatic logic [15:0] saturate(input longint acc);
        longint sh;
        sh = acc >>> 15;
        if (sh > 32767) begin
            return 16'h7fff;
        end else if (sh < -32768) begin
            return 16'h8000;
        end
        return sh[15:0];
    endfunction

    // Walk the program image as the run would, up to HALT
    task automatic model_run(output logic [15:0] l, output logic [15:0] r);
        longint acc;
        logic [31:0] w;
        acc = 0;
        l = '0;
        r = '0;
        for (int i = 0; i < 32; i++) begin
            w = prog[i];
            if (w[31:28] == 4'h1) begin
                acc += longint'(samp[w[27:24]]) * longint'($signed(w[15:0]));
            end else if (w[31:28] == 4'h2) begin
                if (w[16]) r = saturate(acc);
                else l = saturate(acc);
                acc = 0;
            end else if (w[31:28] == 4'hf) begin
                break;
            end
        end
    endtask

    function automatic logic [31:0] mk(input logic [3:0] op, input logic [3:0] ch,
                                       input logic side, input logic [15:0] c);
        return {op, ch, 7'h0, side, c};
    endfunction

    task automatic host_trial();
        logic [31:0] r;
        logic [15:0] el;
        logic [15:0] er;
        int n;
        int f;
        n = 4 + ($unsigned($random(seed)) % 22);
        for (int i = 0; i < 16; i++) begin
            samp[i] = $random(seed);
            bus_write(ADDR_INPUT + 16'(i * 4), {16'h0, samp[i]});
        end
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            prog[i] = mk((r[1:0] == 2'd0) ? 4'h0 : (r[2] ? 4'h1 : 4'h2),
                         r[7:4], r[8], $random(seed));
        end
        // Tail makes sure both sides are written
        r = $random(seed);
        prog[n] = mk(4'h1, r[3:0], 1'b0, $random(seed));
        prog[n + 1] = mk(4'h2, 4'h0, 1'b0, 16'h0);
        prog[n + 2] = mk(4'h1, r[7:4], 1'b0, $random(seed));
        prog[n + 3] = mk(4'h2, 4'h0, 1'b1, 16'h0);
        prog[n + 4] = mk(4'hf, 4'h0, 1'b0, 16'h0);
        for (int i = 0; i <= n + 4; i++) begin
            bus_write(ADDR_COEF + 16'(i * 4), prog[i]);
        end
        model_run(el, er);
        wait_frames(2);
        f = frame_cnt;
        wait_done();
        bus_read(ADDR_RESULT, r);
        check_eq("left", r, {16'h0, el});
        bus_read(ADDR_RESULT + 16'h4, r);
        check_eq("right", r, {16'h0, er});
        while (words_frame != f + 1) begin
            @(negedge ck);
        end
        check_eq("sd left word", word_l, el);
        check_eq("sd right word", word_r, er);
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] el;
        logic [15:0] er;
        rst_n = 1'b0;
        iomem_valid = 1'b0;
        iomem_wstrb = 4'h0;
        iomem_addr = '0;
        iomem_wdata = '0;
        sd_in = 1'b0;
        repeat (5) @(negedge ck);
        rst_n = 1'b1;

        // Clean state after reset, sd silent for a frame
        bus_read(ADDR_STATUS, r);
        check_eq("status", r, 0);
        bus_read(ADDR_RESULT, r);
        check_eq("left", r, 0);
        bus_read(ADDR_RESULT + 16'h4, r);
        check_eq("right", r, 0);
        repeat (130) begin
            @(negedge ck);
            check_eq("sd", sd, 0);
        end

        bus_write(ADDR_STATUS, 32'h1);
        for (int t = 0; t < TRIALS; t++) begin
            host_trial();
        end

        // Samples from sd_in, scaled by one half
        bus_write(ADDR_STATUS, 32'h0);
        for (int i = 0; i < 32; i++) prog[i] = '0;
        prog[0] = mk(4'h1, 4'h0, 1'b0, 16'h4000);
        prog[1] = mk(4'h2, 4'h0, 1'b0, 16'h0);
        prog[2] = mk(4'h1, 4'h1, 1'b0, 16'h4000);
        prog[3] = mk(4'h2, 4'h0, 1'b1, 16'h0);
        prog[4] = mk(4'hf, 4'h0, 1'b0, 16'h0);
        for (int i = 0; i < 5; i++) bus_write(ADDR_COEF + 16'(i * 4), prog[i]);
        in_l = $random(seed);
        in_r = $random(seed);
        samp[0] = in_l;
        samp[1] = in_r;
        model_run(el, er);
        wait_frames(2);
        wait_done();
        bus_read(ADDR_RESULT, r);
        check_eq("left from sd_in", r, {16'h0, el});
        bus_read(ADDR_RESULT + 16'h4, r);
        check_eq("right from sd_in", r, {16'h0, er});

        // Program longer than a frame overruns
        for (int i = 0; i < 50; i++) begin
            bus_write(ADDR_COEF + 16'(i * 4), mk(4'h1, 4'(i), 1'b0, 16'h0100));
        end
        bus_write(ADDR_COEF + 16'(50 * 4), mk(4'hf, 4'h0, 1'b0, 16'h0));
        bus_write(ADDR_STATUS, 32'h1);
        wait_frames(2);
        bus_read(ADDR_STATUS, r);
        check_eq("status error bit", r[1], 1);
        bus_write(ADDR_RESET, 32'h0);
        bus_read(ADDR_STATUS, r);
        check_eq("status after soft reset", r, 0);
        check_eq("control after soft reset", audio_engine_i.host_audio, 0);

        if (audio_engine_i.audio_engine_chk_i.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
